//--- sources.f
+incdir+common
common/commit_pkg.sv
common/csr_pkg.sv
hdl/csr_interface.sv
csr_regfile/csr_regfile.sv
hdl/commit_csr_top.sv
tests/tb_clock_gen.sv
tests/tb_commit_csr.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_commit_csr -o sim_commit_csr
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/sim_commit_csr
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation ended with status $sim_status"
fi
exit $sim_status

//--- tests/tb_commit_csr.sv
`include "core_defs.svh"

module tb_commit_csr;

    import commit_pkg::*;
    import csr_pkg::*;

    // Row control bits
    localparam logic [7:0] S0_INV = 8'h01, S0_XC = 8'h02, S1_INV = 8'h04, S1_XC = 8'h08;
    localparam logic [7:0] TRAP = 8'h10, MEMX = 8'h20, STALL = 8'h40, RND = 8'h80;
    localparam logic [`XLEN-1:0] S0_CAUSE = 64'd2;    // Illegal instruction
    localparam logic [`XLEN-1:0] MEM_CAUSE = 64'd7;   // Store access fault
    localparam logic [`XLEN-1:0] MEM_OFS = 64'h40;

    typedef struct packed {
        instr_type_t                t0;
        logic [4:0]                 rs1;
        logic [`CSR_ADDR_SIZE-1:0]  addr;
        logic [`XLEN-1:0]           data;    // Slot 0 result, or trap origin
        instr_type_t                t1;
        mem_type_t                  m1;
        logic [4:0]                 fl0;
        logic [4:0]                 fl1;
        logic [7:0]                 ctl;
        logic                       exp_ena;
        logic [1:0]                 exp_ret;
    } row_t;

    logic clk, arst_n;
    gl_instruction_t [`COMMIT_WIDTH-1:0] bundle;
    logic            commit_xcpt, store_or_amo, mem_stall, csr_ena;
    exception_t      mem_xcpt;
    logic [1:0]      retire;
    resp_csr_cpu_t   resp;
    row_t            rows[$];

    // Reference CSR state
    logic [`XLEN-1:0] ref_mscratch, ref_mtvec, ref_mepc, ref_mcause, ref_mtval, ref_minstret;
    logic [4:0]       ref_fflags;

    tb_clock_gen clk_gen_i (.clk_o(clk), .arst_n_o(arst_n));

    commit_csr_top dut_i (
        .clk_i                  (clk),
        .arst_n_i               (arst_n),
        .instruction_to_commit_i(bundle),
        .commit_xcpt_i          (commit_xcpt),
        .commit_store_or_amo_i  (store_or_amo),
        .mem_commit_stall_i     (mem_stall),
        .exception_mem_commit_i (mem_xcpt),
        .csr_ena_int_o          (csr_ena),
        .retire_inst_o          (retire),
        .resp_csr_cpu_o         (resp)
    );

    task automatic add_row(input instr_type_t t0, input logic [4:0] rs1,
                           input logic [`CSR_ADDR_SIZE-1:0] addr, input logic [`XLEN-1:0] data,
                           input instr_type_t t1, input mem_type_t m1, input logic [4:0] fl0,
                           input logic [4:0] fl1, input logic [7:0] ctl, input logic ena,
                           input logic [1:0] ret);
        rows.push_back({t0, rs1, addr, data, t1, m1, fl0, fl1, ctl, ena, ret});
    endtask

    // CSRRS with rs1 = 0 is a plain read
    task automatic queue_csr_read(input logic [`CSR_ADDR_SIZE-1:0] addr);
        add_row(CSRRS, 5'd0, addr, 64'd0, ALU, NOT_MEM, 5'd0, 5'd0, 8'd0, 1'b1, 2'b01);
    endtask

    task automatic check_val(input string name, input logic [`XLEN-1:0] exp_v,
                             input logic [`XLEN-1:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERROR at time %0t: %s expected %h, actual %h", $time, name, exp_v, act_v);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic logic [`XLEN-1:0] model_value(input logic [`CSR_ADDR_SIZE-1:0] addr);
        case (addr)
            `CSR_FFLAGS:   return {{(`XLEN-5){1'b0}}, ref_fflags};
            `CSR_MTVEC:    return ref_mtvec;
            `CSR_MSCRATCH: return ref_mscratch;
            `CSR_MEPC:     return ref_mepc;
            `CSR_MCAUSE:   return ref_mcause;
            `CSR_MTVAL:    return ref_mtval;
            `CSR_MINSTRET: return ref_minstret;
            default:       return '0;
        endcase
    endfunction

    // State after the clock edge that ends this row
    task automatic update_model(input row_t r, input logic [`XLEN-1:0] pc0);
        logic [`XLEN-1:0] old_v;
        logic [`XLEN-1:0] opnd;
        logic [`XLEN-1:0] new_v;
        logic             wr;
        logic             trap;
        logic [1:0]       cnt;
        old_v = model_value(r.addr);
        trap  = (r.ctl & TRAP) != 8'd0;
        opnd  = (r.t0 == CSRRWI || r.t0 == CSRRSI || r.t0 == CSRRCI) ?
                {{(`XLEN-5){1'b0}}, r.rs1} : r.data;
        new_v = old_v;
        wr    = r.exp_ena;
        case (r.t0)
            CSRRW, CSRRWI: new_v = opnd;
            CSRRS, CSRRSI: new_v = old_v | opnd;
            CSRRC, CSRRCI: new_v = old_v & ~opnd;
            default:       wr = 1'b0;   // SYS and plain instructions
        endcase
        if (r.rs1 == 5'd0 && r.t0 != CSRRW && r.t0 != CSRRWI) wr = 1'b0;
        cnt = (r.exp_ret == 2'b11) ? 2'd2 : (r.exp_ret == 2'b01 && !trap) ? 2'd1 : 2'd0;
        ref_fflags   = ref_fflags | (r.exp_ret[0] ? r.fl0 : 5'd0) | (r.exp_ret[1] ? r.fl1 : 5'd0);
        ref_minstret = ref_minstret + 64'(cnt);
        if (wr) begin
            case (r.addr)
                `CSR_FFLAGS:   ref_fflags   = new_v[4:0];
                `CSR_MTVEC:    ref_mtvec    = new_v;
                `CSR_MSCRATCH: ref_mscratch = new_v;
                `CSR_MEPC:     ref_mepc     = new_v;
                `CSR_MCAUSE:   ref_mcause   = new_v;
                `CSR_MTVAL:    ref_mtval    = new_v;
                `CSR_MINSTRET: ref_minstret = new_v;
                default: ;
            endcase
        end
        if (trap) begin
            ref_mepc   = pc0;
            ref_mcause = ((r.ctl & MEMX) != 8'd0) ? MEM_CAUSE : S0_CAUSE;
            ref_mtval  = ((r.ctl & MEMX) != 8'd0) ? r.data + MEM_OFS : r.data;
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (!arst_n) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                $display("Reset was not released within 20 clock cycles");
                $display("Test failed");
                $fatal(1, "Reset timeout");
            end
        end
    endtask

    initial begin
        row_t             r;
        gl_instruction_t  s0, s1;
        logic [`XLEN-1:0] pc0;
        logic [31:0]      rnd;
        rnd = $urandom(32'h21194993);
        bundle = '0;
        commit_xcpt = 1'b0;
        store_or_amo = 1'b0;
        mem_stall = 1'b0;
        mem_xcpt = '0;
        {ref_mscratch, ref_mtvec, ref_mepc, ref_mcause, ref_mtval, ref_minstret} = '0;
        ref_fflags = '0;

        add_row(ALU, 5'd0, 12'h000, 64'd0, ALU, NOT_MEM, 5'd0, 5'd0, S0_INV | S1_INV, 1'b0, 2'b00);
        queue_csr_read(`CSR_MINSTRET);
        queue_csr_read(`CSR_FFLAGS);
        queue_csr_read(`CSR_MTVEC);
        queue_csr_read(`CSR_MSCRATCH);
        queue_csr_read(`CSR_MEPC);
        queue_csr_read(`CSR_MCAUSE);
        queue_csr_read(`CSR_MTVAL);
        add_row(CSRRW, 5'd5, `CSR_MSCRATCH, 64'h1234_5678_9abc_def0, ALU, NOT_MEM, 5'd0, 5'd0,
                8'd0, 1'b1, 2'b01);
        add_row(CSRRS, 5'd6, `CSR_MSCRATCH, 64'h00ff_00ff, ALU, NOT_MEM, 5'd0, 5'd0, 8'd0, 1'b1, 2'b01);
        add_row(CSRRC, 5'd7, `CSR_MSCRATCH, 64'hf0f0, ALU, NOT_MEM, 5'd0, 5'd0, 8'd0, 1'b1, 2'b01);
        add_row(CSRRC, 5'd0, `CSR_MSCRATCH, 64'hffff, ALU, NOT_MEM, 5'd0, 5'd0, 8'd0, 1'b1, 2'b01);
        add_row(CSRRWI, 5'h1f, `CSR_MTVEC, 64'd0, ALU, NOT_MEM, 5'd0, 5'd0, 8'd0, 1'b1, 2'b01);
        add_row(CSRRSI, 5'h00, `CSR_MTVEC, 64'd0, ALU, NOT_MEM, 5'd0, 5'd0, 8'd0, 1'b1, 2'b01);
        add_row(CSRRCI, 5'h03, `CSR_MTVEC, 64'd0, ALU, NOT_MEM, 5'd0, 5'd0, 8'd0, 1'b1, 2'b01);
        add_row(CSRRSI, 5'h02, `CSR_MTVEC, 64'd0, ALU, NOT_MEM, 5'd0, 5'd0, 8'd0, 1'b1, 2'b01);
        // Dual commit and the cases that block slot 1
        add_row(ALU, 5'd1, 12'h000, 64'd0, ALU, NOT_MEM, 5'h01, 5'h02, 8'd0, 1'b0, 2'b11);
        add_row(ALU, 5'd1, 12'h000, 64'd0, ALU, NOT_MEM, 5'h00, 5'h00, RND, 1'b0, 2'b11);
        add_row(ALU, 5'd1, 12'h000, 64'd0, ALU, NOT_MEM, 5'h00, 5'h00, RND, 1'b0, 2'b11);
        // Known fflags so that flags of blocked slots would show
        add_row(CSRRWI, 5'h01, `CSR_FFLAGS, 64'd0, ALU, NOT_MEM, 5'd0, 5'd0, 8'd0, 1'b1, 2'b01);
        add_row(ALU, 5'd1, 12'h000, 64'd0, ALU, STORE, 5'h00, 5'h10, 8'd0, 1'b0, 2'b01);
        add_row(ALU, 5'd1, 12'h000, 64'd0, FENCE, NOT_MEM, 5'h00, 5'h10, 8'd0, 1'b0, 2'b01);
        add_row(ALU, 5'd1, 12'h000, 64'd0, CSRRW, NOT_MEM, 5'h00, 5'h10, 8'd0, 1'b0, 2'b01);
        add_row(ALU, 5'd1, 12'h000, 64'd0, ALU, NOT_MEM, 5'h00, 5'h08, S1_XC, 1'b0, 2'b01);
        add_row(ALU, 5'd1, 12'h000, 64'd0, ALU, AMO, 5'h00, 5'h10, 8'd0, 1'b0, 2'b01);
        add_row(ALU, 5'd1, 12'h000, 64'd0, ALU, NOT_MEM, 5'h04, 5'h10, STALL, 1'b0, 2'b00);
        queue_csr_read(`CSR_MINSTRET);
        queue_csr_read(`CSR_FFLAGS);
        // Traps from slot 0 and from the memory stage
        add_row(ALU, 5'd1, 12'h000, 64'h8000_1000, ALU, NOT_MEM, 5'h00, 5'h1f, S0_XC | TRAP,
                1'b0, 2'b01);
        queue_csr_read(`CSR_MEPC);
        add_row(ALU, 5'd1, 12'h000, 64'h4000, ALU, NOT_MEM, 5'h08, 5'h1f, TRAP | MEMX, 1'b0, 2'b01);
        queue_csr_read(`CSR_MCAUSE);
        queue_csr_read(`CSR_MTVAL);
        queue_csr_read(`CSR_FFLAGS);
        add_row(CSRRCI, 5'h01, `CSR_FFLAGS, 64'd0, ALU, NOT_MEM, 5'd0, 5'd0, 8'd0, 1'b1, 2'b01);
        queue_csr_read(`CSR_FFLAGS);
        add_row(CSRRW, 5'd9, `CSR_MINSTRET, 64'd100, ALU, NOT_MEM, 5'd0, 5'd0, 8'd0, 1'b1, 2'b01);
        queue_csr_read(`CSR_MINSTRET);
        add_row(ECALL, 5'd3, `CSR_MSCRATCH, 64'hffff, ALU, NOT_MEM, 5'd0, 5'd0, 8'd0, 1'b1, 2'b01);
        add_row(EBREAK, 5'd3, `CSR_MSCRATCH, 64'hffff, ALU, NOT_MEM, 5'd0, 5'd0, 8'd0, 1'b1, 2'b01);
        add_row(MRET, 5'd3, `CSR_MSCRATCH, 64'hffff, ALU, NOT_MEM, 5'd0, 5'd0, 8'd0, 1'b1, 2'b01);
        add_row(WFI, 5'd3, `CSR_MSCRATCH, 64'hffff, ALU, NOT_MEM, 5'd0, 5'd0, 8'd0, 1'b1, 2'b01);
        queue_csr_read(`CSR_MSCRATCH);

        wait_reset_release();
        for (int i = 0; i < rows.size(); i++) begin
            r   = rows[i];
            pc0 = 64'h8000_0000 + 64'(i) * 64'd4;
            rnd = $urandom;
            // Slot 1 stays an unblocked ALU op, so the retire mask is unchanged
            if ((r.ctl & RND) != 8'd0) begin
                r.fl1 = rnd[4:0];
                r.m1  = rnd[8] ? LOAD : NOT_MEM;
            end
            s0 = '0;
            s0.valid = (r.ctl & S0_INV) == 8'd0;
            s0.pc = pc0;
            s0.instr_type = r.t0;
            s0.rs1 = r.rs1;
            s0.rd = 5'd1;
            s0.csr_addr = r.addr;
            s0.result = r.data;
            s0.exception = {(r.ctl & S0_XC) != 8'd0, S0_CAUSE, r.data};
            s0.fp_status = r.fl0;
            s1 = '0;
            s1.valid = (r.ctl & S1_INV) == 8'd0;
            s1.pc = pc0 + 64'd4;
            s1.instr_type = r.t1;
            s1.mem_type = r.m1;
            s1.rd = rnd[20:16];
            s1.result = {$urandom, $urandom};
            s1.exception.valid = (r.ctl & S1_XC) != 8'd0;
            s1.fp_status = r.fl1;

            @(posedge clk);
            bundle[0]    <= s0;
            bundle[1]    <= s1;
            commit_xcpt  <= (r.ctl & TRAP) != 8'd0;
            store_or_amo <= (r.ctl & MEMX) != 8'd0;
            mem_stall    <= (r.ctl & STALL) != 8'd0;
            mem_xcpt     <= {1'b1, MEM_CAUSE, r.data + MEM_OFS};
            @(negedge clk);
            check_val("csr_ena_int_o", 64'(r.exp_ena), 64'(csr_ena));
            check_val("retire_inst_o", 64'(r.exp_ret), 64'(retire));
            check_val("csr_rw_rdata", r.exp_ena ? model_value(r.addr) : '0, resp.csr_rw_rdata);
            check_val("csr_evec", {ref_mtvec[`XLEN-1:2], 2'b00}, resp.csr_evec);
            check_val("csr_epc", ref_mepc, resp.csr_epc);
            update_model(r, pc0);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- tests/tb_clock_gen.sv
// Clock and reset source for the testbench
module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;   // Period 8
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);   // Two cycles in reset
        arst_n_o <= 1'b1;
    end

endmodule

//--- hdl/commit_csr_top.sv
`include "core_defs.svh"

// Commit stage CSR path
module commit_csr_top (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  commit_pkg::gl_instruction_t [`COMMIT_WIDTH-1:0] instruction_to_commit_i,
    input  logic                        commit_xcpt_i,
    input  logic                        commit_store_or_amo_i,
    input  logic                        mem_commit_stall_i,
    input  commit_pkg::exception_t      exception_mem_commit_i,
    output logic                        csr_ena_int_o,
    output logic [1:0]                  retire_inst_o,
    output csr_pkg::resp_csr_cpu_t      resp_csr_cpu_o
);

    import csr_pkg::*;

    req_cpu_csr_t req_cpu_csr;   // Decode to register file

    csr_interface csr_interface_i (
        .instruction_to_commit_i (instruction_to_commit_i),
        .commit_xcpt_i           (commit_xcpt_i),
        .commit_store_or_amo_i   (commit_store_or_amo_i),
        .mem_commit_stall_i      (mem_commit_stall_i),
        .exception_mem_commit_i  (exception_mem_commit_i),
        .csr_ena_int_o           (csr_ena_int_o),
        .req_cpu_csr_o           (req_cpu_csr),
        .retire_inst_o           (retire_inst_o)
    );

    csr_regfile csr_regfile_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .req_cpu_csr_i  (req_cpu_csr),
        .resp_csr_cpu_o (resp_csr_cpu_o)
    );

endmodule

//--- csr_regfile/csr_regfile.sv
`include "core_defs.svh"

// Machine-mode CSR storage
module csr_regfile (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  csr_pkg::req_cpu_csr_t  req_cpu_csr_i,
    output csr_pkg::resp_csr_cpu_t resp_csr_cpu_o
);

    import csr_pkg::*;

    logic [`XLEN-1:0]  mscratch_q, mscratch_d;
    logic [`XLEN-1:0]  mtvec_q,    mtvec_d;
    logic [`XLEN-1:0]  mepc_q,     mepc_d;
    logic [`XLEN-1:0]  mcause_q,   mcause_d;
    logic [`XLEN-1:0]  mtval_q,    mtval_d;
    logic [`XLEN-1:0]  minstret_q, minstret_d;
    logic [4:0]        fflags_q,   fflags_d;

    logic [`XLEN-1:0]  csr_rdata;
    logic [`XLEN-1:0]  csr_wval;
    logic              csr_wen;

    // Old value of the addressed CSR
    always_comb begin
        case (req_cpu_csr_i.csr_rw_addr)
            `CSR_FFLAGS:   csr_rdata = {{(`XLEN-5){1'b0}}, fflags_q};
            `CSR_MTVEC:    csr_rdata = mtvec_q;
            `CSR_MSCRATCH: csr_rdata = mscratch_q;
            `CSR_MEPC:     csr_rdata = mepc_q;
            `CSR_MCAUSE:   csr_rdata = mcause_q;
            `CSR_MTVAL:    csr_rdata = mtval_q;
            `CSR_MINSTRET: csr_rdata = minstret_q;
            default:       csr_rdata = '0;   // Unmapped
        endcase
    end

    // Read-modify-write value
    always_comb begin
        csr_wen  = 1'b1;
        csr_wval = csr_rdata;
        case (req_cpu_csr_i.csr_rw_cmd)
            CSR_CMD_WRITE: csr_wval = req_cpu_csr_i.csr_rw_data;
            CSR_CMD_SET:   csr_wval = csr_rdata | req_cpu_csr_i.csr_rw_data;
            CSR_CMD_CLEAR: csr_wval = csr_rdata & ~req_cpu_csr_i.csr_rw_data;
            default:       csr_wen  = 1'b0;   // NOPE, READ and SYS leave state alone
        endcase
    end

    always_comb begin
        mscratch_d = mscratch_q;
        mtvec_d    = mtvec_q;
        mepc_d     = mepc_q;
        mcause_d   = mcause_q;
        mtval_d    = mtval_q;
        // Background accrual and counting
        fflags_d   = fflags_q | req_cpu_csr_i.fp_status;
        minstret_d = minstret_q + {{(`XLEN-2){1'b0}}, req_cpu_csr_i.csr_retire};

        // Explicit write wins over accrual and increment
        if (csr_wen) begin
            case (req_cpu_csr_i.csr_rw_addr)
                `CSR_FFLAGS:   fflags_d   = csr_wval[4:0];
                `CSR_MTVEC:    mtvec_d    = csr_wval;
                `CSR_MSCRATCH: mscratch_d = csr_wval;
                `CSR_MEPC:     mepc_d     = csr_wval;
                `CSR_MCAUSE:   mcause_d   = csr_wval;
                `CSR_MTVAL:    mtval_d    = csr_wval;
                `CSR_MINSTRET: minstret_d = csr_wval;
                default: ;
            endcase
        end

        // Trap capture
        if (req_cpu_csr_i.csr_exception) begin
            mepc_d   = req_cpu_csr_i.csr_pc;
            mcause_d = req_cpu_csr_i.csr_xcpt_cause;
            mtval_d  = req_cpu_csr_i.csr_rw_data;   // Faulting address
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mscratch_q <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
            minstret_q <= '0;
            fflags_q   <= '0;
        end else begin
            mscratch_q <= mscratch_d;
            mtvec_q    <= mtvec_d;
            mepc_q     <= mepc_d;
            mcause_q   <= mcause_d;
            mtval_q    <= mtval_d;
            minstret_q <= minstret_d;
            fflags_q   <= fflags_d;
        end
    end

    assign resp_csr_cpu_o.csr_rw_rdata = csr_rdata;
    assign resp_csr_cpu_o.csr_evec     = {mtvec_q[`XLEN-1:2], 2'b00};   // Mode bits dropped
    assign resp_csr_cpu_o.csr_epc      = mepc_q;

endmodule

//--- hdl/csr_interface.sv
`include "core_defs.svh"

// Commit bundle to CSR request translation and retire decision
module csr_interface (
    input  commit_pkg::gl_instruction_t [`COMMIT_WIDTH-1:0] instruction_to_commit_i,
    input  logic                        commit_xcpt_i,          // Slot 0 traps
    input  logic                        commit_store_or_amo_i,  // Trap info from memory stage
    input  logic                        mem_commit_stall_i,
    input  commit_pkg::exception_t      exception_mem_commit_i,
    output logic                        csr_ena_int_o,
    output csr_pkg::req_cpu_csr_t       req_cpu_csr_o,
    output logic [1:0]                  retire_inst_o
);

    import commit_pkg::*;
    import csr_pkg::*;

    gl_instruction_t   slot0;
    gl_instruction_t   slot1;
    exception_t        xcpt_sel;
    csr_cmd_t          csr_cmd_int;
    logic [`XLEN-1:0]  csr_rw_data_int;
    logic              csr_ena_int;
    logic              slot1_type_blocks;
    logic              commit_2_blocked;
    logic [1:0]        retire_mask;
    logic [1:0]        retire_cnt;

    assign slot0 = instruction_to_commit_i[0];
    assign slot1 = instruction_to_commit_i[1];

    // Slot 0 decode into command and operand
    always_comb begin
        csr_cmd_int     = CSR_CMD_NOPE;
        csr_rw_data_int = '0;
        csr_ena_int     = 1'b0;
        if (slot0.valid && !slot0.exception.valid) begin
            case (slot0.instr_type)
                CSRRW: begin
                    csr_cmd_int     = CSR_CMD_WRITE;
                    csr_rw_data_int = slot0.result;
                    csr_ena_int     = 1'b1;
                end
                CSRRS: begin
                    csr_cmd_int     = (slot0.rs1 == 5'd0) ? CSR_CMD_READ : CSR_CMD_SET;
                    csr_rw_data_int = slot0.result;
                    csr_ena_int     = 1'b1;
                end
                CSRRC: begin
                    csr_cmd_int     = (slot0.rs1 == 5'd0) ? CSR_CMD_READ : CSR_CMD_CLEAR;
                    csr_rw_data_int = slot0.result;
                    csr_ena_int     = 1'b1;
                end
                CSRRWI: begin
                    csr_cmd_int     = CSR_CMD_WRITE;
                    csr_rw_data_int = {{(`XLEN-5){1'b0}}, slot0.rs1};   // zimm
                    csr_ena_int     = 1'b1;
                end
                CSRRSI: begin
                    csr_cmd_int     = (slot0.rs1 == 5'd0) ? CSR_CMD_READ : CSR_CMD_SET;
                    csr_rw_data_int = {{(`XLEN-5){1'b0}}, slot0.rs1};
                    csr_ena_int     = 1'b1;
                end
                CSRRCI: begin
                    csr_cmd_int     = (slot0.rs1 == 5'd0) ? CSR_CMD_READ : CSR_CMD_CLEAR;
                    csr_rw_data_int = {{(`XLEN-5){1'b0}}, slot0.rs1};
                    csr_ena_int     = 1'b1;
                end
                ECALL, EBREAK, MRET, WFI: begin
                    csr_cmd_int = CSR_CMD_SYS;
                    csr_ena_int = 1'b1;
                end
                default: begin
                    csr_ena_int = 1'b0;
                end
            endcase
        end
    end

    // Types that must commit alone in slot 1
    always_comb begin
        case (slot1.instr_type)
            CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
            ECALL, EBREAK, MRET, WFI,
            FENCE, FENCE_I:           slot1_type_blocks = 1'b1;
            default:                  slot1_type_blocks = 1'b0;
        endcase
    end

    assign commit_2_blocked = csr_ena_int || !slot1.valid || slot1.exception.valid ||
                              slot1_type_blocks ||
                              (slot1.mem_type == STORE) || (slot1.mem_type == AMO);

    always_comb begin
        retire_mask = 2'b00;
        retire_cnt  = 2'd0;
        if (slot0.valid && commit_xcpt_i) begin
            retire_mask = 2'b01;   // Trapping instruction leaves but is not counted
        end else if (slot0.valid && !mem_commit_stall_i) begin
            retire_mask = commit_2_blocked ? 2'b01 : 2'b11;
            retire_cnt  = commit_2_blocked ? 2'd1  : 2'd2;
        end
    end

    // Trap info source
    assign xcpt_sel = commit_store_or_amo_i ? exception_mem_commit_i : slot0.exception;

    assign req_cpu_csr_o.csr_rw_addr    = csr_ena_int ? slot0.csr_addr : '0;
    assign req_cpu_csr_o.csr_rw_cmd     = csr_cmd_int;   // NOPE whenever no request
    assign req_cpu_csr_o.csr_rw_data    = csr_ena_int ? csr_rw_data_int : xcpt_sel.origin;
    assign req_cpu_csr_o.csr_exception  = commit_xcpt_i;
    assign req_cpu_csr_o.csr_xcpt_cause = xcpt_sel.cause;
    assign req_cpu_csr_o.csr_pc         = slot0.pc;
    assign req_cpu_csr_o.csr_retire     = retire_cnt;

    // Only retired slots contribute flags
    assign req_cpu_csr_o.fp_status = (slot0.fp_status & {5{retire_mask[0]}}) |
                                     (slot1.fp_status & {5{retire_mask[1]}});

    assign csr_ena_int_o = csr_ena_int;
    assign retire_inst_o = retire_mask;

endmodule

//--- common/csr_pkg.sv
`include "core_defs.svh"

package csr_pkg;

    // Operation requested from the CSR file
    typedef enum logic [2:0] {
        CSR_CMD_NOPE,
        CSR_CMD_READ,
        CSR_CMD_WRITE,
        CSR_CMD_SET,
        CSR_CMD_CLEAR,
        CSR_CMD_SYS
    } csr_cmd_t;

    // Commit side to CSR file
    typedef struct packed {
        logic [`CSR_ADDR_SIZE-1:0]  csr_rw_addr;
        csr_cmd_t                   csr_rw_cmd;
        logic [`XLEN-1:0]           csr_rw_data;     // Operand, or trap value when idle
        logic                       csr_exception;
        logic [`XLEN-1:0]           csr_xcpt_cause;
        logic [`XLEN-1:0]           csr_pc;
        logic [4:0]                 fp_status;       // Flags of retired slots
        logic [1:0]                 csr_retire;      // Retired instruction count
    } req_cpu_csr_t;

    // CSR file back to the core
    typedef struct packed {
        logic [`XLEN-1:0] csr_rw_rdata;   // Old value of addressed CSR
        logic [`XLEN-1:0] csr_evec;       // Trap vector base
        logic [`XLEN-1:0] csr_epc;        // Return address for MRET
    } resp_csr_cpu_t;

endpackage

//--- common/commit_pkg.sv
`include "core_defs.svh"

package commit_pkg;

    // Instruction classes seen at commit
    typedef enum logic [3:0] {
        ALU,
        CSRRW,
        CSRRS,
        CSRRC,
        CSRRWI,
        CSRRSI,
        CSRRCI,
        ECALL,
        EBREAK,
        MRET,
        WFI,
        FENCE,
        FENCE_I
    } instr_type_t;

    // Memory access kind of the instruction
    typedef enum logic [1:0] {
        NOT_MEM,
        LOAD,
        STORE,
        AMO
    } mem_type_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  cause;
        logic [`XLEN-1:0]  origin;   // Faulting address
    } exception_t;

    // Accrued IEEE flags, same bit order as fflags
    typedef struct packed {
        logic nv;   // Invalid operation
        logic dz;   // Divide by zero
        logic of;   // Overflow
        logic uf;   // Underflow
        logic nx;   // Inexact
    } fp_status_t;

    // One entry of the commit bundle
    typedef struct packed {
        logic                       valid;
        logic [`XLEN-1:0]           pc;
        instr_type_t                instr_type;
        mem_type_t                  mem_type;
        logic [4:0]                 rs1;        // Register index or zimm
        logic [4:0]                 rd;
        logic [`CSR_ADDR_SIZE-1:0]  csr_addr;
        logic [`XLEN-1:0]           result;     // rs1 value for register forms
        exception_t                 exception;
        fp_status_t                 fp_status;
    } gl_instruction_t;

endpackage

//--- common/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath and register width
`define XLEN          64
`define CSR_ADDR_SIZE 12
// Instructions presented per commit bundle
`define COMMIT_WIDTH  2

// Machine-mode CSR address map
`define CSR_FFLAGS    12'h001
`define CSR_MTVEC     12'h305
`define CSR_MSCRATCH  12'h340
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MTVAL     12'h343
`define CSR_MINSTRET  12'hB02

`endif
